// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_text_display
FILELIST   := vlog.f
FLAGS      := --binary --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the testbench output holds the pass line
run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: font.hex
// one glyph row per line as two hex digits, the msb is the leftmost pixel
// addresses run glyph 0 (code 0x20) rows 0 to 15, then glyph 1, then glyph 2
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
18
18
18
18
18
18
18
00
18
18
00
00
00
00
00
00
ff
81
81
bd
a5
a5
bd
81
81
ff
00
00
00
00

// File: font_rom.sv
`timescale 1ns/100ps

module font_rom
	import text_pkg::*;
(
	input  logic        clk,
	input  logic [10:0] rom_addr,
	output logic [7:0]  row_bits
);

	// 128 glyphs of GLYPH_H rows each, one byte per glyph row
	logic [7:0] rom [0:128*GLYPH_H-1];

	// glyphs missing from the file stay blank
	initial begin
		for (int i = 0; i < 128 * GLYPH_H; i++) begin
			rom[i] = 8'h00;
		end
		$readmemh("font.hex", rom);
	end

	// registered read keeps the pipeline at one clock per stage
	always_ff @(posedge clk) begin
		row_bits <= rom[rom_addr];
	end

endmodule

// File: glyph_pipe.sv
`timescale 1ns/100ps

module glyph_pipe
	import text_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  scan_t       scan,
	output logic [11:0] rd_addr,
	input  logic [7:0]  code,
	output logic [10:0] rom_addr,
	input  logic [7:0]  row_bits,
	output logic        h_sync,
	output logic        v_sync,
	output logic        pixel
);

	// only the position inside the glyph travels down the pipe
	logic [2:0] px_d1;
	logic [2:0] px_d2;
	logic [3:0] gy_d1;
	logic       active_d1;
	logic       active_d2;
	logic       h_sync_d1;
	logic       v_sync_d1;
	logic [6:0] glyph;

	// stage 0 turns the scan position into a cell index
	assign rd_addr = 12'(scan.y / GLYPH_H) * 12'(COLS) + 12'(scan.x / GLYPH_W);

	// stage 1 has the character, so the glyph row can be fetched
	assign glyph    = 7'(code - 8'(CHAR_BASE));
	assign rom_addr = {glyph, gy_d1};

	// syncs idle high and the picture is dark coming out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_d1 <= 1'b0;
			active_d2 <= 1'b0;
			h_sync_d1 <= 1'b1;
			v_sync_d1 <= 1'b1;
			h_sync    <= 1'b1;
			v_sync    <= 1'b1;
		end else begin
			active_d1 <= scan.active;
			active_d2 <= active_d1;
			h_sync_d1 <= scan.h_sync;
			v_sync_d1 <= scan.v_sync;
			h_sync    <= h_sync_d1;
			v_sync    <= v_sync_d1;
		end
	end

	// position inside the glyph, delayed to meet the memory reads
	always_ff @(posedge clk) begin
		px_d1 <= 3'(scan.x % GLYPH_W);
		px_d2 <= px_d1;
		gy_d1 <= 4'(scan.y % GLYPH_H);
	end

	// stage 2 picks one bit, the leftmost pixel sits in the msb
	assign pixel = active_d2 & row_bits[3'(GLYPH_W - 1) - px_d2];

endmodule

// File: scan_timing.sv
`timescale 1ns/100ps

module scan_timing
	import text_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	output scan_t scan
);

	logic [9:0] x;
	logic [9:0] y;
	logic       x_last;
	logic       y_last;
	logic       active;
	logic       h_sync;
	logic       v_sync;

	// the line ends on the last pixel clock and the frame on the last line
	assign x_last = (x == 10'(H_TOTAL - 1));
	assign y_last = (y == 10'(V_TOTAL - 1));

	// x runs every clock and y steps once per line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x <= '0;
			y <= '0;
		end else begin
			if (x_last) begin
				x <= '0;
				if (y_last) begin
					y <= '0;
				end else begin
					y <= y + 10'd1;
				end
			end else begin
				x <= x + 10'd1;
			end
		end
	end

	// visible area is the top left corner of the counter space
	assign active = (x < 10'(H_ACTIVE)) && (y < 10'(V_ACTIVE));

	// both syncs are negative pulses placed after the front porch
	assign h_sync = !((x >= 10'(H_ACTIVE + H_FRONT)) &&
		(x < 10'(H_ACTIVE + H_FRONT + H_SYNC)));
	assign v_sync = !((y >= 10'(V_ACTIVE + V_FRONT)) &&
		(y < 10'(V_ACTIVE + V_FRONT + V_SYNC)));

	// the decoded flags stay combinational so they line up with x and y
	assign scan.x      = x;
	assign scan.y      = y;
	assign scan.active = active;
	assign scan.h_sync = h_sync;
	assign scan.v_sync = v_sync;

	// a sync pulse inside the visible area would tear the picture
	a_hsync_blank: assert property (@(posedge clk) disable iff (!rst_n)
		scan.active |-> scan.h_sync)
		else $error("h_sync low inside the active region");

endmodule

// File: tb_text_display.sv
`timescale 1ns/100ps

module tb_text_display
	import text_pkg::*;
();

	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// six frames of sync measuring and capture, one spare frame, and room for clears
	localparam int TIMEOUT_CYCLES = 7 * FRAME_CYCLES + 25 * CELLS;

	logic      clk;
	logic      rst_n;
	logic      cmd_strobe;
	host_cmd_t cmd;
	logic      busy;
	logic      h_sync;
	logic      v_sync;
	logic      pixel;

	// reference screen, cursor and font
	logic [7:0]  ref_screen [0:CELLS-1];
	logic [7:0]  ref_font [0:2047];
	int          ref_col = 0;
	int          ref_row = 0;
	logic [31:0] lfsr = 32'h3d238b80;
	string       cur_test;
	int          test_errors = 0;
	int          pixel_base = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          total_errors = 0;
	int          cycle_count = 0;

	// output position rebuilt from the syncs, and the frame capture state
	int   cap_x = 0;
	int   cap_y = 0;
	bit   x_locked = 1'b0;
	bit   y_locked = 1'b0;
	logic prev_h = 1'b1;
	logic prev_v = 1'b1;
	int   capture_req = 0;
	int   capture_done = 0;
	bit   capturing = 1'b0;
	int   cap_count = 0;
	int   shown = 0;
	int   pixel_errors = 0;
	int   blank_errors = 0;

	text_display text_display_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.busy       (busy),
		.h_sync     (h_sync),
		.v_sync     (v_sync),
		.pixel      (pixel)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// watchdog so a stuck busy or a dead sync cannot hang the run
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d clock cycles in test %s", cycle_count, cur_test);
			$display("Regression failed");
			$finish;
		end
	end

	// taps 32, 22, 2 and 1, shifting towards the msb
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic sync_level(input bit vertical);
		return vertical ? v_sync : h_sync;
	endfunction

	// expected pixel at screen position (x, y) from the reference screen
	function automatic logic expected_pixel(input int x, input int y);
		int         code;
		logic [7:0] bits;
		if (x >= H_ACTIVE || y >= V_ACTIVE) begin
			return 1'b0;
		end
		code = int'(ref_screen[12'((y / GLYPH_H) * COLS + x / GLYPH_W)]);
		// the glyph number wraps at 128 so codes below the base land at the top
		bits = ref_font[11'(((code - CHAR_BASE) & 127) * GLYPH_H + y % GLYPH_H)];
		return bits[3'(7 - x % GLYPH_W)];
	endfunction

	// same cursor rules as the writer, applied when a command is accepted
	task automatic model_cmd(input op_t op, input logic [7:0] code);
		case (op)
			OP_PUT: begin
				ref_screen[12'(ref_row * COLS + ref_col)] = code;
				ref_col = ref_col + 1;
				if (ref_col == COLS) begin
					ref_col = 0;
					ref_row = (ref_row + 1) % ROWS;
				end
			end
			OP_NEWLINE: begin
				ref_col = 0;
				ref_row = (ref_row + 1) % ROWS;
			end
			default: begin
				// a clear blanks every cell and then homes like OP_HOME
				if (op == OP_CLEAR) begin
					for (int i = 0; i < CELLS; i++) begin
						ref_screen[12'(i)] = BLANK_CODE;
					end
				end
				ref_col = 0;
				ref_row = 0;
			end
		endcase
	endtask

	// entered 2 ns after a rising edge with busy low, leaves the same way
	task automatic send_cmd(input op_t op, input logic [7:0] code);
		cmd_strobe = 1'b1;
		cmd.op = op;
		cmd.code = code;
		@(posedge clk);
		#2;
		cmd_strobe = 1'b0;
		model_cmd(op, code);
	endtask

	task automatic put_random(input int count);
		int r;
		for (int n = 0; n < count; n++) begin
			r = 0;
			// two fresh bits per character, folded onto the three defined glyphs
			for (int b = 0; b < 2; b++) begin
				lfsr = lfsr_next(lfsr);
				r = (r << 1) | int'(lfsr[0]);
			end
			send_cmd(OP_PUT, 8'(CHAR_BASE + r % 3));
		end
	endtask

	task automatic wait_idle();
		while (busy) begin
			@(posedge clk);
			#2;
		end
	endtask

	// number of clocks that busy stays high, counted at falling edges
	task automatic count_busy(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (busy) begin
			cycles++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	// low width and period of one sync, from one falling edge to the next
	task automatic measure_sync(input bit vertical, output int low, output int period);
		logic prev;
		logic now;
		now = sync_level(vertical);
		prev = now;
		while (!(prev && !now)) begin
			prev = now;
			@(negedge clk);
			now = sync_level(vertical);
		end
		low = 0;
		period = 0;
		while (!now) begin
			low++;
			period++;
			@(negedge clk);
			now = sync_level(vertical);
		end
		while (now) begin
			period++;
			@(negedge clk);
			now = sync_level(vertical);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic capture_frame();
		// give the last write time to reach the text memory
		repeat (4) @(posedge clk);
		capture_req = capture_req + 1;
		while (capture_done != capture_req) begin
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("[ERROR] %s %s: expected %0d actual %0d", cur_test, what, expected, actual);
		test_errors = test_errors + 1;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = 0;
		pixel_base = pixel_errors;
	endtask

	task automatic end_test();
		int errs;
		errs = test_errors + pixel_errors - pixel_base;
		tests_run++;
		total_errors = total_errors + errs;
		if (errs == 0) begin
			$display("test %s ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, errs);
		end
	endtask

	// outputs settle just after the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin
		logic want;
		// x restarts at the first sync pixel and y at the first sync line
		if (prev_h && !h_sync) begin
			cap_x = H_ACTIVE + H_FRONT;
			x_locked = 1'b1;
		end else begin
			cap_x = (cap_x + 1) % H_TOTAL;
		end
		if (prev_v && !v_sync) begin
			cap_y = V_ACTIVE + V_FRONT;
			y_locked = 1'b1;
		end else if (cap_x == 0) begin
			cap_y = (cap_y + 1) % V_TOTAL;
		end
		prev_h = h_sync;
		prev_v = v_sync;
		// a capture covers any run of one frame's worth of positions
		if (capturing) begin
			want = expected_pixel(cap_x, cap_y);
			if (pixel !== want) begin
				pixel_errors = pixel_errors + 1;
				if (shown < 8) begin
					$display("[ERROR] %s pixel (%0d,%0d): expected %0b actual %0b",
						cur_test, cap_x, cap_y, want, pixel);
				end
				shown++;
			end
			if (pixel === 1'b1 && (cap_x >= H_ACTIVE || cap_y >= V_ACTIVE)) begin
				blank_errors = blank_errors + 1;
			end
			cap_count = cap_count + 1;
			if (cap_count == FRAME_CYCLES) begin
				capturing = 1'b0;
				capture_done = capture_req;
			end
		end else if (capture_req != capture_done && x_locked && y_locked) begin
			capturing = 1'b1;
			cap_count = 0;
			shown = 0;
		end
	end

	initial begin
		int low;
		int period;
		int cycles;
		rst_n = 1'b0;
		cmd_strobe = 1'b0;
		cmd.op = OP_PUT;
		cmd.code = 8'h00;
		cur_test = "reset";
		for (int i = 0; i < 2048; i++) begin
			ref_font[11'(i)] = 8'h00;
		end
		$readmemh("font.hex", ref_font);
		model_cmd(OP_CLEAR, BLANK_CODE);
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		wait_idle();

		begin_test("sync_timing");
		measure_sync(1'b0, low, period);
		if (low != H_SYNC) begin
			report_mismatch("h_sync low cycles", H_SYNC, low);
		end
		if (period != H_TOTAL) begin
			report_mismatch("h_sync period cycles", H_TOTAL, period);
		end
		measure_sync(1'b1, low, period);
		if (low != V_SYNC * H_TOTAL) begin
			report_mismatch("v_sync low cycles", V_SYNC * H_TOTAL, low);
		end
		if (period != FRAME_CYCLES) begin
			report_mismatch("v_sync period cycles", FRAME_CYCLES, period);
		end
		end_test();

		begin_test("reset_clear");
		capture_frame();
		end_test();

		begin_test("random_puts");
		put_random(200);
		capture_frame();
		end_test();

		begin_test("newline_home");
		send_cmd(OP_HOME, 8'h00);
		put_random(3);
		// down to the last row, then a run of puts that wraps onto row 0
		repeat (29) send_cmd(OP_NEWLINE, 8'h00);
		put_random(85);
		// the thirtieth newline wraps from the last row back to the top
		repeat (30) send_cmd(OP_NEWLINE, 8'h00);
		put_random(2);
		capture_frame();
		end_test();

		begin_test("clear");
		send_cmd(OP_CLEAR, 8'h00);
		count_busy(cycles);
		if (cycles != CELLS) begin
			report_mismatch("busy cycles", CELLS, cycles);
		end
		capture_frame();
		end_test();

		begin_test("blanking");
		if (blank_errors != 0) begin
			report_mismatch("lit pixels outside the active region", 0, blank_errors);
		end
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
		if (tests_failed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: text_display.sv
`timescale 1ns/100ps

module text_display
	import text_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_strobe,
	input  host_cmd_t cmd,
	output logic      busy,
	output logic      h_sync,
	output logic      v_sync,
	output logic      pixel
);

	scan_t       scan;
	text_wr_t    wr;
	logic [11:0] rd_addr;
	logic [7:0]  code;
	logic [10:0] rom_addr;
	logic [7:0]  row_bits;

	// free running scan position and raw syncs
	scan_timing scan_timing_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.scan  (scan)
	);

	// host commands become writes into the text memory
	text_writer text_writer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.busy       (busy),
		.wr         (wr)
	);

	// character codes, written by the host and read by the scan
	text_ram text_ram_inst (
		.clk     (clk),
		.wr      (wr),
		.rd_addr (rd_addr),
		.code    (code)
	);

	font_rom font_rom_inst (
		.clk      (clk),
		.rom_addr (rom_addr),
		.row_bits (row_bits)
	);

	// two stage lookup that lines the pixel up with the delayed syncs
	glyph_pipe glyph_pipe_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.scan     (scan),
		.rd_addr  (rd_addr),
		.code     (code),
		.rom_addr (rom_addr),
		.row_bits (row_bits),
		.h_sync   (h_sync),
		.v_sync   (v_sync),
		.pixel    (pixel)
	);

endmodule

// File: text_pkg.sv
package text_pkg;

	// horizontal timing in pixel clocks for 640x480 at 60 Hz
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// vertical timing in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// character grid and glyph cell size
	localparam int COLS      = 80;
	localparam int ROWS      = 30;
	localparam int CELLS     = COLS * ROWS;
	localparam int GLYPH_W   = 8;
	localparam int GLYPH_H   = 16;
	// glyph 0 in the font holds the character with this code
	localparam int CHAR_BASE = 32;
	// a clear fills every cell with a space
	localparam logic [7:0] BLANK_CODE = 8'h20;

	typedef enum logic [1:0] {OP_PUT, OP_NEWLINE, OP_HOME, OP_CLEAR} op_t;

	typedef struct packed {
		op_t        op;
		logic [7:0] code;
	} host_cmd_t;

	typedef struct packed {
		logic        en;
		logic [11:0] addr;
		logic [7:0]  code;
	} text_wr_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active;
		logic       h_sync;
		logic       v_sync;
	} scan_t;

	typedef enum logic {ST_IDLE, ST_CLEAR} writer_state_t;

endpackage

// File: text_ram.sv
`timescale 1ns/100ps

module text_ram
	import text_pkg::*;
(
	input  logic        clk,
	input  text_wr_t    wr,
	input  logic [11:0] rd_addr,
	output logic [7:0]  code
);

	// one byte per character cell, the top part past the grid is never used
	logic [7:0] mem [0:4095];

	// host side write port
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.code;
		end
	end

	// display side read port runs every clock
	// a write to the same cell in the same clock shows up one clock later
	always_ff @(posedge clk) begin
		code <= mem[rd_addr];
	end

endmodule

// File: text_writer.sv
`timescale 1ns/100ps

module text_writer
	import text_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_strobe,
	input  host_cmd_t cmd,
	output logic      busy,
	output text_wr_t  wr
);

	writer_state_t state;
	logic [6:0]    col;
	logic [4:0]    row;
	logic [11:0]   clr_cnt;
	logic          accept;
	logic [4:0]    row_next;
	logic [11:0]   cur_addr;
	logic          wr_en;
	logic [11:0]   wr_addr;
	logic [7:0]    wr_code;

	// the writer is busy for the whole of a clear and idle otherwise
	assign busy   = (state == ST_CLEAR);
	assign accept = cmd_strobe && !busy;

	// the row after the cursor row, with no scrolling it wraps to the top
	assign row_next = (row == 5'(ROWS - 1)) ? 5'd0 : row + 5'd1;

	// cell index of the cursor in row major order
	assign cur_addr = 12'(row) * 12'(COLS) + 12'(col);

	// state, cursor and the write strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// power up blanks the screen before the host can write
			state   <= ST_CLEAR;
			clr_cnt <= '0;
			col     <= '0;
			row     <= '0;
			wr_en   <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			case (state)
				ST_CLEAR: begin
					// one cell per clock until the last one is written
					wr_en   <= 1'b1;
					clr_cnt <= clr_cnt + 12'd1;
					if (clr_cnt == 12'(CELLS - 1)) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					if (accept) begin
						case (cmd.op)
							OP_PUT: begin
								// write at the cursor then step right
								wr_en <= 1'b1;
								if (col == 7'(COLS - 1)) begin
									col <= '0;
									row <= row_next;
								end else begin
									col <= col + 7'd1;
								end
							end
							OP_NEWLINE: begin
								col <= '0;
								row <= row_next;
							end
							OP_HOME: begin
								col <= '0;
								row <= '0;
							end
							OP_CLEAR: begin
								// the cursor homes as the clear starts
								col     <= '0;
								row     <= '0;
								clr_cnt <= '0;
								state   <= ST_CLEAR;
							end
						endcase
					end
				end
			endcase
		end
	end

	// address and data of the write follow the strobe by one clock
	always_ff @(posedge clk) begin
		if (state == ST_CLEAR) begin
			wr_addr <= clr_cnt;
			wr_code <= BLANK_CODE;
		end else begin
			wr_addr <= cur_addr;
			wr_code <= cmd.code;
		end
	end

	assign wr = '{en: wr_en, addr: wr_addr, code: wr_code};

	// the host has to hold off while a clear is running
	a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_strobe |-> !busy)
		else $error("command strobe while busy");

	// every write lands inside the visible grid
	a_wr_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
		wr.en |-> (wr.addr < 12'(CELLS)))
		else $error("text write outside the grid");

endmodule

// File: vlog.f
text_pkg.sv
scan_timing.sv
text_writer.sv
text_ram.sv
font_rom.sv
glyph_pipe.sv
text_display.sv
tb_text_display.sv
